// File: Makefile
# Verilator build and run of the timing block testbench

SRCS = sys_timing_pkg.sv reset_sequencer.sv tick_divider.sv countdown_timer.sv \
	timer_control.sv sys_timing_top.sv tb_sys_timing.sv

# rebuilt only when a source or the file list changes
obj_dir/Vtb_sys_timing: sources.f $(SRCS)
	verilator --binary --timing --top-module tb_sys_timing -Mdir obj_dir -f sources.f

run: obj_dir/Vtb_sys_timing
	./obj_dir/Vtb_sys_timing | tee sim.log
	@grep -q "Test passed" sim.log
	@! grep -q "Test failed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

// File: countdown_timer.sv
/* one countdown channel, stepped by the ms tick,
   with load, start, stop, ack strobes and a sticky expired flag */

`timescale 1ns/1ps

module countdown_timer (
	input  logic                   clk25,
	input  logic                   rst,
	input  logic                   tick,		// ms step
	input  logic                   load,		// strobe from control
	input  sys_timing_pkg::count_t load_value,
	input  logic                   start,
	input  logic                   stop,
	input  logic                   ack,		// clears expired
	output sys_timing_pkg::count_t count,
	output logic                   running,
	output logic                   expired		// sticky until ack
);

	logic step;	// tick that actually acts on the count
	logic hit;	// this step ends the countdown

	// a load on the same edge as a tick wins outright
	assign step = tick && running && !load;

	// count of 1 reaches zero now, count of 0 expires at once
	assign hit = step && (count <= 1);

	// ============================================================
	// count
	// ============================================================
	always_ff @(posedge clk25) begin
		if (rst)
			count <= '0;
		else if (load)
			count <= load_value;
		else if (step && count != '0)
			count <= count - 1'b1;	// zero is left as is
	end

	// ============================================================
	// flags
	// ============================================================
	always_ff @(posedge clk25) begin
		if (rst) begin
			running <= 1'b0;
			expired <= 1'b0;
		end else begin
			// start over stop, then expiry ends the run (one-shot)
			if (start)
				running <= 1'b1;
			else if (stop || hit)
				running <= 1'b0;

			// new expiry beats an ack on the same edge
			if (hit)
				expired <= 1'b1;
			else if (ack)
				expired <= 1'b0;
		end
	end

	// only one of load/start/stop/ack is ever high in a cycle,
	// the control sends one strobe per accepted command
	// a restart after expiry needs OP_LOAD and OP_START again

endmodule

// File: reset_sequencer.sv
/* reset sequencer, holds the internal reset
   until lock is present and a fixed hold has run out */

`timescale 1ns/1ps

module reset_sequencer #(
	parameter int RST_HOLD = 16	// cycles of hold after rst and lock clear
) (
	input  logic clk25,
	input  logic rst,		// external reset, sync
	input  logic pll_locked,	// lock flag from the clock source
	output logic sys_rst		// sequenced internal reset
);

	// counter stops at RST_HOLD, one extra state so it never wraps
	localparam int HOLD_W = $clog2(RST_HOLD + 1);
	localparam logic [HOLD_W-1:0] HOLD_END  = HOLD_W'(RST_HOLD);
	localparam logic [HOLD_W-1:0] HOLD_LAST = HOLD_W'(RST_HOLD - 1);

	logic [HOLD_W-1:0] hold_cnt;	// cycles seen with rst low and lock up

	// hold_cnt is k-1 on the k-th clean edge, so
	// sys_rst drops on edge RST_HOLD after release
	always_ff @(posedge clk25) begin
		if (rst || !pll_locked) begin
			hold_cnt <= '0;		// any loss of lock restarts the hold
			sys_rst  <= 1'b1;
		end else begin
			if (hold_cnt != HOLD_END)
				hold_cnt <= hold_cnt + HOLD_W'(1);	// saturate
			sys_rst <= (hold_cnt < HOLD_LAST);
		end
	end

	// rst and pll_locked are both taken as sync to clk25
	// lock drop shows on sys_rst one edge later

endmodule

// File: sources.f
sys_timing_pkg.sv
reset_sequencer.sv
tick_divider.sv
countdown_timer.sv
timer_control.sv
sys_timing_top.sv
tb_sys_timing.sv

// File: sys_timing_pkg.sv
/* shared widths, count and response word types,
   timer index type and command opcodes for the timing block */

package sys_timing_pkg;

	// ============================================================
	// widths
	// ============================================================
	localparam int COUNT_W    = 16;	// one timer count
	localparam int RSP_W      = 32;	// response word, wide enough for uptime
	localparam int MAX_TIMERS = 8;	// upper bound on the timer bank

	typedef logic [COUNT_W-1:0] count_t;
	typedef logic [RSP_W-1:0]   rsp_word_t;	// timer reads come back zero-extended

	// index wide enough to name any timer up to the bound
	typedef logic [$clog2(MAX_TIMERS)-1:0] timer_idx_t;

	// ============================================================
	// command opcodes
	// ============================================================
	typedef enum logic [2:0] {
		OP_LOAD   = 3'd0,	// cmd_data into count
		OP_START  = 3'd1,	// set running
		OP_STOP   = 3'd2,	// clear running
		OP_ACK    = 3'd3,	// clear sticky expired
		OP_READ   = 3'd4,	// count plus flags back
		OP_UPTIME = 3'd5	// ms uptime back
	} timer_op_t;

	// codes 6 and 7 unused, accepted and dropped

endpackage

// File: sys_timing_top.sv
/* timing block top level with reset sequencer, ms and frame dividers,
   the countdown timer bank and the command control */

`timescale 1ns/1ps

module sys_timing_top #(
	parameter int CLK_FREQ    = 25_000_000,	// clk25 rate in Hz
	parameter int NUM_TIMERS  = 4,		// 1 .. MAX_TIMERS
	parameter int RST_HOLD    = 4096,	// hold after lock, in cycles
	parameter int PULSE_WIDTH = 4		// stretched pulse width
) (
	input  logic                       clk25,
	input  logic                       rst,
	input  logic                       pll_locked,
	input  logic                       cmd_valid,
	input  sys_timing_pkg::timer_op_t  cmd_op,
	input  sys_timing_pkg::timer_idx_t cmd_timer,
	input  sys_timing_pkg::count_t     cmd_data,
	input  logic                       rsp_ready,
	output logic                       sys_rst,
	output logic                       cmd_ready,
	output logic                       rsp_valid,
	output sys_timing_pkg::rsp_word_t  rsp_data,
	output logic                       rsp_running,
	output logic                       rsp_expired,
	output logic                       irq,
	output logic                       tick_1khz,	// one cycle per ms
	output logic                       pulse_1khz,	// widened ms pulse
	output logic                       pulse_60hz	// widened frame pulse
);

	import sys_timing_pkg::*;

	// timer bank wiring
	logic [NUM_TIMERS-1:0]   tmr_load;
	logic [NUM_TIMERS-1:0]   tmr_start;
	logic [NUM_TIMERS-1:0]   tmr_stop;
	logic [NUM_TIMERS-1:0]   tmr_ack;
	logic [NUM_TIMERS-1:0]   tmr_running;
	logic [NUM_TIMERS-1:0]   tmr_expired;
	count_t                  tmr_value;
	count_t [NUM_TIMERS-1:0] tmr_count;

	// ============================================================
	// reset and dividers
	// ============================================================
	reset_sequencer #(.RST_HOLD(RST_HOLD)) i_reset_sequencer (
		.clk25      (clk25),
		.rst        (rst),
		.pll_locked (pll_locked),
		.sys_rst    (sys_rst)
	);

	tick_divider #(.DIVISOR(CLK_FREQ / 1000), .PULSE_WIDTH(PULSE_WIDTH)) i_ms_divider (
		.clk25 (clk25),
		.rst   (sys_rst),
		.tick  (tick_1khz),
		.pulse (pulse_1khz)
	);

	// frame rate, only the widened pulse leaves the block
	tick_divider #(.DIVISOR(CLK_FREQ / 60), .PULSE_WIDTH(PULSE_WIDTH)) i_frame_divider (
		.clk25 (clk25),
		.rst   (sys_rst),
		.tick  (),
		.pulse (pulse_60hz)
	);

	// ============================================================
	// timer bank and control
	// ============================================================
	for (genvar i = 0; i < NUM_TIMERS; i++) begin : g_timer
		countdown_timer i_countdown_timer (
			.clk25      (clk25),
			.rst        (sys_rst),
			.tick       (tick_1khz),
			.load       (tmr_load[i]),
			.load_value (tmr_value),
			.start      (tmr_start[i]),
			.stop       (tmr_stop[i]),
			.ack        (tmr_ack[i]),
			.count      (tmr_count[i]),
			.running    (tmr_running[i]),
			.expired    (tmr_expired[i])
		);
	end

	timer_control #(.NUM_TIMERS(NUM_TIMERS)) i_timer_control (
		.clk25       (clk25),
		.rst         (sys_rst),
		.tick        (tick_1khz),
		.cmd_valid   (cmd_valid),
		.cmd_ready   (cmd_ready),
		.cmd_op      (cmd_op),
		.cmd_timer   (cmd_timer),
		.cmd_data    (cmd_data),
		.rsp_valid   (rsp_valid),
		.rsp_ready   (rsp_ready),
		.rsp_data    (rsp_data),
		.rsp_running (rsp_running),
		.rsp_expired (rsp_expired),
		.irq         (irq),
		.tmr_load    (tmr_load),
		.tmr_start   (tmr_start),
		.tmr_stop    (tmr_stop),
		.tmr_ack     (tmr_ack),
		.tmr_value   (tmr_value),
		.tmr_count   (tmr_count),
		.tmr_running (tmr_running),
		.tmr_expired (tmr_expired)
	);

endmodule

// File: tb_sys_timing.sv
/* testbench for the timing block with LFSR stimulus, a cycle model of
   timers, ticks and uptime, and a response compare process */

`timescale 1ns/1ps

module tb_sys_timing;

	import sys_timing_pkg::*;

	localparam int NT         = 4;		// timers in the DUT
	localparam int HOLD       = 16;		// reset hold cycles
	localparam int MS_DIV     = 20;		// 20 kHz clock, 1 ms
	localparam int FRAME_DIV  = 333;	// 20000 / 60
	localparam int PW         = 4;
	localparam int MAX_CYCLES = 40000;	// sequence below needs about 17k

	logic       clk25      = 1'b0;
	logic       rst        = 1'b1;
	logic       pll_locked = 1'b0;
	logic       cmd_valid  = 1'b0;
	timer_op_t  cmd_op     = OP_LOAD;
	timer_idx_t cmd_timer  = '0;
	count_t     cmd_data   = '0;
	logic       rsp_ready  = 1'b1;
	logic       sys_rst;
	logic       cmd_ready;
	logic       rsp_valid;
	rsp_word_t  rsp_data;
	logic       rsp_running;
	logic       rsp_expired;
	logic       irq;
	logic       tick_1khz;
	logic       pulse_1khz;
	logic       pulse_60hz;

	// ============================================================
	// reference model state
	// ============================================================
	count_t        m_count [NT];
	logic [NT-1:0] m_run       = '0;
	logic [NT-1:0] m_exp       = '0;
	rsp_word_t     m_uptime    = '0;	// ticks since sys_rst fell
	logic          m_irq       = 1'b0;
	logic          m_rsp       = 1'b0;	// response pending
	logic [33:0]   exp_q [$];		// {running, expired, data}
	int            clean       = 0;	// edges with rst low and lock up
	int            up_cyc      = 0;	// cycles since sys_rst fell
	int            rst_run     = 0;
	logic          exp_sys_rst = 1'b1;
	logic          rst_known   = 1'b0;

	logic [31:0]   lfsr     = 32'h97fe_4ee5;
	logic          stall    = 1'b0;	// random rsp_ready when set
	int            errors   = 0;
	int            checks   = 0;
	int            cycles   = 0;
	logic          held     = 1'b0;
	logic [33:0]   held_word;
	logic          was_xfer = 1'b0;

	sys_timing_top #(
		.CLK_FREQ    (20000),
		.NUM_TIMERS  (NT),
		.RST_HOLD    (HOLD),
		.PULSE_WIDTH (PW)
	) i_sys_timing_top (.*);

	always #50 clk25 = ~clk25;	// 100 ns period

	// ============================================================
	// helpers
	// ============================================================
	task automatic check(input logic [63:0] got, input logic [63:0] want, input string what);
		checks++;
		if (got !== want) begin
			errors++;
			$display("ERROR at time %0t: %s, got %0h expected %0h", $time, what, got, want);
		end
	endtask

	// fibonacci taps 32 22 2 1, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int k = 0; k < n; k++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r    = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic int rand_value();
		return int'(rand_bits(6)) % 40 + 1;	// 1 .. 40 ms
	endfunction

	// expected response from the command and the model as it stands
	function automatic logic [33:0] expect_rsp(input timer_op_t op, input int idx);
		if (op == OP_UPTIME)
			return {2'b00, m_uptime};
		if (idx >= NT)
			return '0;	// no such timer
		return {m_run[idx], m_exp[idx], 16'h0000, m_count[idx]};
	endfunction

	task automatic step_cycle();
		@(posedge clk25);
		rsp_ready <= stall ? (rand_bits(2) != 0) : 1'b1;	// ready 3 of 4 when stalling
	endtask

	task automatic wait_cycles(input int n);
		repeat (n)
			step_cycle();
	endtask

	// hold the command until cmd_ready is seen on an edge
	task automatic send_cmd(input timer_op_t op, input int idx, input int data);
		step_cycle();
		cmd_valid <= 1'b1;
		cmd_op    <= op;
		cmd_timer <= timer_idx_t'(idx);
		cmd_data  <= count_t'(data);
		step_cycle();
		while (!cmd_ready)
			step_cycle();
		cmd_valid <= 1'b0;	// transferred on this edge
	endtask

	task automatic wait_idle();
		step_cycle();
		while (rsp_valid)
			step_cycle();
	endtask

	// ============================================================
	// model and per-cycle checks, all on pre-edge values
	// ============================================================
	always @(posedge clk25) begin : model
		logic acc;
		logic ld;
		logic st;
		logic sp;
		logic ak;
		logic stp;
		logic hit;
		int   ph_ms;
		int   ph_fr;

		if (rst_known)
			check(64'(sys_rst), 64'(exp_sys_rst), "sys_rst");
		if (rst || !pll_locked)
			clean = 0;	// hold restarts
		else if (clean < HOLD)
			clean++;
		exp_sys_rst = (clean < HOLD);

		if (!rst_known || sys_rst) begin
			if (rst_known)
				rst_run++;
			// the first reset cycle still shows the last live values
			if (rst_run >= 2)
				check(64'({cmd_ready, rsp_valid, irq, tick_1khz, pulse_1khz, pulse_60hz}),
					64'd0, "outputs during reset");
			up_cyc   = 0;
			m_run    = '0;
			m_exp    = '0;
			m_uptime = '0;
			m_irq    = 1'b0;
			m_rsp    = 1'b0;
			for (int i = 0; i < NT; i++)
				m_count[i] = '0;
			exp_q.delete();
		end else begin
			rst_run = 0;
			up_cyc++;
			ph_ms = (up_cyc - 1) % MS_DIV + 1;	// 1 .. 20
			ph_fr = (up_cyc - 1) % FRAME_DIV + 1;
			check(64'(tick_1khz), 64'(ph_ms == MS_DIV), "tick_1khz");
			check(64'(pulse_1khz), 64'(ph_ms > MS_DIV - PW), "pulse_1khz");
			check(64'(pulse_60hz), 64'(ph_fr > FRAME_DIV - PW), "pulse_60hz");
			check(64'(irq), 64'(m_irq), "irq");
			check(64'(rsp_valid), 64'(m_rsp), "rsp_valid");
			check(64'(cmd_ready), 64'(up_cyc > 1 && !m_rsp), "cmd_ready");
			m_irq = |m_exp;	// shows one cycle later

			acc = cmd_valid && up_cyc > 1 && !m_rsp;	// transfer as the model sees it
			if (acc && (cmd_op == OP_READ || cmd_op == OP_UPTIME)) begin
				exp_q.push_back(expect_rsp(cmd_op, int'(cmd_timer)));
				m_rsp = 1'b1;	// valid from the next cycle
			end else if (rsp_ready) begin
				m_rsp = 1'b0;	// transfer done, drops next edge
			end

			for (int i = 0; i < NT; i++) begin
				ld  = acc && cmd_op == OP_LOAD && int'(cmd_timer) == i;
				st  = acc && cmd_op == OP_START && int'(cmd_timer) == i;
				sp  = acc && cmd_op == OP_STOP && int'(cmd_timer) == i;
				ak  = acc && cmd_op == OP_ACK && int'(cmd_timer) == i;
				stp = tick_1khz && m_run[i] && !ld;	// load beats a tick
				hit = stp && m_count[i] <= count_t'(1);	// 1 reaches 0, 0 expires at once
				if (ld)
					m_count[i] = cmd_data;
				else if (stp && m_count[i] != '0)
					m_count[i] = m_count[i] - count_t'(1);
				if (st)
					m_run[i] = 1'b1;
				else if (sp || hit)
					m_run[i] = 1'b0;	// one-shot
				if (hit)
					m_exp[i] = 1'b1;
				else if (ak)
					m_exp[i] = 1'b0;
			end
			if (tick_1khz)
				m_uptime += 1;
		end
		rst_known = 1'b1;
	end

	// ============================================================
	// response compare
	// ============================================================
	always @(posedge clk25) begin : compare
		logic [33:0] got;

		got = {rsp_running, rsp_expired, rsp_data};
		if (sys_rst !== 1'b0) begin
			held     = 1'b0;
			was_xfer = 1'b0;
		end else begin
			if (held) begin	// stalled word must sit still
				check(64'(rsp_valid), 64'd1, "rsp_valid dropped during stall");
				check(64'(got), 64'(held_word), "response changed during stall");
			end
			if (was_xfer)
				check(64'(rsp_valid), 64'd0, "rsp_valid after transfer");
			if (rsp_valid && rsp_ready) begin
				if (exp_q.size() == 0) begin
					$display("response at time %0t with no read or uptime command", $time);
					errors++;
				end else begin
					check(64'(got), 64'(exp_q.pop_front()), "response word");
				end
			end
			held      = rsp_valid && !rsp_ready;
			held_word = got;
			was_xfer  = rsp_valid && rsp_ready;
		end
	end

	always @(posedge clk25) begin : watchdog
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
			$display("Test failed");
			$finish;
		end
	end

	// ============================================================
	// stimulus
	// ============================================================
	initial begin : stimulus
		int op;

		repeat (10)
			step_cycle();
		rst <= 1'b0;
		repeat (3)
			step_cycle();
		pll_locked <= 1'b1;	// lock after rst, hold counts from here
		while (sys_rst)
			step_cycle();

		// load then read, 4 .. 7 are out of range
		for (int i = 0; i < 8; i++) begin
			send_cmd(OP_LOAD, i, rand_value());
			send_cmd(OP_READ, i, 0);
		end

		// countdown to expiry with reads along the way
		for (int i = 0; i < NT; i++)
			send_cmd(OP_START, i, 0);
		repeat (60) begin
			wait_cycles(int'(rand_bits(5)));
			send_cmd(OP_READ, int'(rand_bits(2)), 0);
		end
		send_cmd(OP_UPTIME, 0, 0);
		for (int i = 0; i < NT; i++) begin
			send_cmd(OP_ACK, i, 0);
			send_cmd(OP_READ, i, 0);
		end
		wait_cycles(4);

		// stop part way, counts hold
		for (int i = 0; i < NT; i++) begin
			send_cmd(OP_LOAD, i, 30 + i);
			send_cmd(OP_START, i, 0);
		end
		wait_cycles(100);
		for (int i = 0; i < NT; i++)
			send_cmd(OP_STOP, i, 0);
		repeat (2) begin
			for (int i = 0; i < NT; i++)
				send_cmd(OP_READ, i, 0);
			wait_cycles(200);
		end
		send_cmd(OP_UPTIME, 0, 0);

		// random commands under rsp_ready stalls
		stall = 1'b1;
		repeat (400) begin
			op = int'(rand_bits(3)) % 6;
			send_cmd(timer_op_t'(op), int'(rand_bits(3)), rand_value());
			wait_cycles(int'(rand_bits(6)));
		end
		stall = 1'b0;
		wait_idle();

		// lock loss, then a second loss inside the hold
		pll_locked <= 1'b0;
		wait_cycles(5);
		pll_locked <= 1'b1;
		wait_cycles(8);
		pll_locked <= 1'b0;
		wait_cycles(2);
		pll_locked <= 1'b1;
		step_cycle();
		while (sys_rst)
			step_cycle();
		send_cmd(OP_LOAD, 1, 5);
		send_cmd(OP_START, 1, 0);
		wait_cycles(150);
		send_cmd(OP_READ, 1, 0);
		send_cmd(OP_UPTIME, 0, 0);
		wait_idle();
		wait_cycles(10);

		if (exp_q.size() != 0) begin
			$display("%0d expected responses never arrived", exp_q.size());
			errors++;
		end
		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: tick_divider.sv
/* clock divider giving a one-cycle tick at the terminal count
   and a stretched pulse over the last cycles of each period */

`timescale 1ns/1ps

module tick_divider #(
	parameter int DIVISOR     = 25000,	// period in clk25 cycles
	parameter int PULSE_WIDTH = 4		// stretched pulse width in cycles
) (
	input  logic clk25,
	input  logic rst,	// sequenced reset from the sequencer
	output logic tick,	// one cycle per period
	output logic pulse	// PULSE_WIDTH cycles, ends on the tick
);

	// ============================================================
	// period counter
	// ============================================================
	localparam int CNT_W = $clog2(DIVISOR + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DIVISOR);
	localparam logic [CNT_W-1:0] CNT_ONE  = CNT_W'(1);
	// first count of the widened pulse
	localparam logic [CNT_W-1:0] PULSE_FIRST = CNT_W'(DIVISOR - PULSE_WIDTH + 1);

	logic [CNT_W-1:0] div_cnt;	// runs 1 .. DIVISOR

	// held at 1 in reset, so count k shows on cycle k after release
	always_ff @(posedge clk25) begin
		if (rst)
			div_cnt <= CNT_ONE;
		else if (div_cnt == CNT_LAST)
			div_cnt <= CNT_ONE;		// wrap back to 1, never 0
		else
			div_cnt <= div_cnt + CNT_ONE;
	end

	// ============================================================
	// outputs
	// ============================================================
	// decoded straight from the count
	// reset holds the count at 1, which is below both compares
	// as long as DIVISOR exceeds PULSE_WIDTH
	assign tick  = (div_cnt == CNT_LAST);
	assign pulse = (div_cnt >= PULSE_FIRST);	// last PULSE_WIDTH counts

	// with 20 kHz clock and DIVISOR 20, pulse covers counts 17 .. 20
	// frame divider at 333 covers 330 .. 333

endmodule

// File: timer_control.sv
/* command decode, per-timer strobes, ms uptime counter,
   held read response and registered interrupt for the timer bank */

`timescale 1ns/1ps

module timer_control #(
	parameter int NUM_TIMERS = 4
) (
	input  logic                                    clk25,
	input  logic                                    rst,
	input  logic                                    tick,		// ms tick
	// command port
	input  logic                                    cmd_valid,
	output logic                                    cmd_ready,
	input  sys_timing_pkg::timer_op_t               cmd_op,
	input  sys_timing_pkg::timer_idx_t              cmd_timer,
	input  sys_timing_pkg::count_t                  cmd_data,
	// response port
	output logic                                    rsp_valid,
	input  logic                                    rsp_ready,
	output sys_timing_pkg::rsp_word_t               rsp_data,
	output logic                                    rsp_running,
	output logic                                    rsp_expired,
	output logic                                    irq,
	// timer bank side
	output logic [NUM_TIMERS-1:0]                   tmr_load,
	output logic [NUM_TIMERS-1:0]                   tmr_start,
	output logic [NUM_TIMERS-1:0]                   tmr_stop,
	output logic [NUM_TIMERS-1:0]                   tmr_ack,
	output sys_timing_pkg::count_t                  tmr_value,	// shared load value
	input  sys_timing_pkg::count_t [NUM_TIMERS-1:0] tmr_count,
	input  logic [NUM_TIMERS-1:0]                   tmr_running,
	input  logic [NUM_TIMERS-1:0]                   tmr_expired
);

	import sys_timing_pkg::*;

	logic                  live;		// low during reset and the cycle after
	logic                  accept;		// command transfers this edge
	logic                  wants_rsp;	// read or uptime
	logic [NUM_TIMERS-1:0] sel;		// one-hot addressed timer
	count_t                rd_count;
	logic                  rd_running;
	logic                  rd_expired;
	rsp_word_t             uptime;		// ms since sys_rst fell

	// ============================================================
	// command handshake
	// ============================================================
	// no new command while a response is held
	assign cmd_ready = live && !rsp_valid;
	assign accept    = cmd_valid && cmd_ready;
	assign wants_rsp = (cmd_op == OP_READ) || (cmd_op == OP_UPTIME);

	always_ff @(posedge clk25) begin
		if (rst)
			live <= 1'b0;
		else
			live <= 1'b1;
	end

	// address decode and read mux
	// an index past NUM_TIMERS matches nothing and reads back zero
	always_comb begin
		sel        = '0;
		rd_count   = '0;
		rd_running = 1'b0;
		rd_expired = 1'b0;
		for (int i = 0; i < NUM_TIMERS; i++) begin
			if (cmd_timer == timer_idx_t'(i)) begin
				sel[i]     = 1'b1;
				rd_count   = tmr_count[i];
				rd_running = tmr_running[i];
				rd_expired = tmr_expired[i];
			end
		end
	end

	// ============================================================
	// per-timer strobes
	// ============================================================
	// one cycle wide, timers act on the transfer edge
	assign tmr_load  = sel & {NUM_TIMERS{accept && (cmd_op == OP_LOAD)}};
	assign tmr_start = sel & {NUM_TIMERS{accept && (cmd_op == OP_START)}};
	assign tmr_stop  = sel & {NUM_TIMERS{accept && (cmd_op == OP_STOP)}};
	assign tmr_ack   = sel & {NUM_TIMERS{accept && (cmd_op == OP_ACK)}};
	assign tmr_value = cmd_data;	// only sampled where tmr_load is set

	// ============================================================
	// uptime and interrupt
	// ============================================================
	always_ff @(posedge clk25) begin
		if (rst) begin
			uptime <= '0;
			irq    <= 1'b0;
		end else begin
			if (tick)
				uptime <= uptime + 1'b1;	// wraps after 2^32 ms
			irq <= |tmr_expired;	// one cycle behind the flags
		end
	end

	// ============================================================
	// response
	// ============================================================
	always_ff @(posedge clk25) begin
		if (rst)
			rsp_valid <= 1'b0;
		else if (accept && wants_rsp)
			rsp_valid <= 1'b1;
		else if (rsp_ready)
			rsp_valid <= 1'b0;	// transfer done, drop next edge
	end

	// snapshot at the transfer edge, values as they stood that cycle
	// held unchanged since no command is accepted while rsp_valid is up
	always_ff @(posedge clk25) begin
		if (accept) begin
			case (cmd_op)
				OP_READ: begin
					rsp_data    <= rsp_word_t'(rd_count);	// zero-extend
					rsp_running <= rd_running;
					rsp_expired <= rd_expired;
				end
				OP_UPTIME: begin
					rsp_data    <= uptime;	// pre-increment value
					rsp_running <= 1'b0;
					rsp_expired <= 1'b0;
				end
				default: ;	// no response for the rest
			endcase
		end
	end

endmodule
